// ==== Bender.yml ====
package:
  name: wt_cache

sources:
  - logic/cache_pkg.sv
  - logic/cache_bank.sv
  - logic/line_select.sv
  - logic/cache_ctrl.sv
  - logic/cache_top.sv
  - target: test
    files:
      - bench/cache_checker.sv
      - bench/tb_cache.sv

// ==== bench/cache_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_checker #(
    parameter int NUM_BANKS = 4,
    parameter int LINES     = 16
) (
    input  wire                              clock,
    input  wire                              rst_n,
    input  wire                              cpu_cyc,
    input  wire                              cpu_stb,
    input  wire                              cpu_we,
    input  wire  [cache_pkg::ADDR_W-1:0]     cpu_adr,
    input  wire  [cache_pkg::DATA_W-1:0]     cpu_dat_w,
    input  wire  [cache_pkg::SEL_W-1:0]      cpu_sel,
    input  wire  [cache_pkg::DATA_W-1:0]     cpu_dat_r,
    input  wire                              cpu_ack,
    input  wire                              mem_cyc,
    input  wire                              mem_stb,
    input  wire                              mem_we,
    input  wire  [cache_pkg::ADDR_W-1:0]     mem_adr,
    input  wire  [cache_pkg::DATA_W-1:0]     mem_dat_w,
    input  wire  [cache_pkg::SEL_W-1:0]      mem_sel,
    input  wire                              mem_ack,
    output int                               error_count,
    output int                               tests_done
);

    localparam int LINE_LSB = 2 + $clog2(NUM_BANKS);
    localparam int TAG_LSB  = LINE_LSB + $clog2(LINES);

    logic [31:0] shadow [logic [29:0]];
    logic        line_valid [LINES];
    logic [31:0] line_tag [LINES];
    string       cur_name;
    int          cur_reads_exp;
    int          rd_count;
    int          wr_count;
    int          test_errors;
    int          req_cycles;
    bit          req_seen;
    bit          ack_seen_q;

    initial begin
        error_count = 0;
        tests_done  = 0;
        cur_name    = "reset idle";
    end

    ////////////////////
    // Shadow memory
    ////////////////////

    function automatic logic [31:0] init_word(input logic [29:0] waddr);
        return {2'b00, waddr} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [29:0] waddr);
        if (shadow.exists(waddr)) begin
            return shadow[waddr];
        end
        return init_word(waddr);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////
    // Reporting
    ////////////////////

    task automatic flag_mismatch(input string what, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        $display("Mismatch in %s: %s expected %08h, actual %08h",
                 cur_name, what, exp_val, act_val);
        test_errors++;
        error_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error in %s: %s", cur_name, msg);
        test_errors++;
        error_count++;
    endtask

    // Called by the testbench between requests
    task automatic start_test(input string name, input int reads_exp);
        cur_name      = name;
        cur_reads_exp = reads_exp;
        rd_count      = 0;
        wr_count      = 0;
        test_errors   = 0;
        req_cycles    = 0;
    endtask

    task automatic print_summary();
        $display("Tests finished: %0d, errors: %0d", tests_done, error_count);
    endtask

    ////////////////////
    // Request end
    ////////////////////

    task automatic finish_request();
        int          idx;
        bit          hit;
        int          reads_exp;
        logic [31:0] exp_data;
        idx = int'(cpu_adr[TAG_LSB-1:LINE_LSB]);
        hit = line_valid[idx] && (line_tag[idx] == (cpu_adr >> TAG_LSB));
        if (cpu_we) begin
            // Write miss leaves the line model alone
            reads_exp = 0;
            if (wr_count != 1) begin
                flag_mismatch("memory writes", 1, wr_count);
            end
        end else begin
            reads_exp = hit ? 0 : NUM_BANKS;
            exp_data  = shadow_word(cpu_adr[31:2]);
            if (cpu_dat_r !== exp_data) begin
                flag_mismatch("read data", exp_data, cpu_dat_r);
            end
            if (wr_count != 0) begin
                flag_mismatch("memory writes", 0, wr_count);
            end
            // Hit answers two cycles after the request is first seen
            if (hit && req_cycles != 2) begin
                flag_mismatch("hit latency", 2, req_cycles);
            end
            if (!hit) begin
                line_valid[idx] = 1'b1;
                line_tag[idx]   = cpu_adr >> TAG_LSB;
            end
        end
        if (rd_count != reads_exp) begin
            flag_mismatch("memory reads", reads_exp, rd_count);
        end
        if (cur_reads_exp != reads_exp) begin
            note_failure("table and line model disagree on the memory read count");
        end
        tests_done++;
        $display("%s %s (memory reads %0d, writes %0d)",
                 (test_errors == 0) ? "ok  " : "FAIL", cur_name, rd_count, wr_count);
    endtask

    ////////////////////
    // Port watch
    ////////////////////

    always @(posedge clock) begin
        if (!rst_n) begin
            for (int l = 0; l < LINES; l++) begin
                line_valid[l] = 1'b0;
            end
            req_seen   = 1'b0;
            ack_seen_q = 1'b0;
        end else begin
            if (!req_seen && (cpu_ack || mem_cyc)) begin
                note_failure("cpu_ack or mem_cyc went high before the first request");
            end
            if (cpu_cyc && cpu_stb) begin
                req_seen = 1'b1;
            end
            // Memory bus goes idle for one cycle after each mem_ack
            if (ack_seen_q && mem_cyc) begin
                note_failure("mem_cyc stayed high in the cycle after mem_ack");
            end
            ack_seen_q = mem_cyc && mem_stb && mem_ack;
            if (mem_cyc && mem_stb && mem_ack) begin
                if (mem_we) begin
                    wr_count++;
                    if (mem_adr !== {cpu_adr[31:2], 2'b00}) begin
                        flag_mismatch("write address", {cpu_adr[31:2], 2'b00}, mem_adr);
                    end
                    if (mem_sel !== cpu_sel) begin
                        flag_mismatch("write sel", cpu_sel, mem_sel);
                    end
                    if (mem_dat_w !== cpu_dat_w) begin
                        flag_mismatch("write data", cpu_dat_w, mem_dat_w);
                    end
                    shadow[cpu_adr[31:2]] = merge_bytes(shadow_word(cpu_adr[31:2]),
                                                        cpu_dat_w, cpu_sel);
                end else begin
                    rd_count++;
                    // Refill must stay inside the requested line
                    if (mem_adr[31:LINE_LSB] !== cpu_adr[31:LINE_LSB]) begin
                        flag_mismatch("refill address", cpu_adr, mem_adr);
                    end
                end
            end
            if (cpu_cyc && cpu_stb && cpu_ack) begin
                finish_request();
            end else if (cpu_cyc && cpu_stb) begin
                req_cycles++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cache;

    localparam int NUM_BANKS = 4;
    localparam int LINES     = 16;
    localparam int NUM_TESTS = 11;
    localparam int ACK_LIMIT = 200;

    logic        clock;
    logic        rst_n;
    logic        cpu_cyc;
    logic        cpu_stb;
    logic        cpu_we;
    logic [31:0] cpu_adr;
    logic [31:0] cpu_dat_w;
    logic [3:0]  cpu_sel;
    logic [31:0] cpu_dat_r;
    logic        cpu_ack;
    logic        mem_cyc;
    logic        mem_stb;
    logic        mem_we;
    logic [31:0] mem_adr;
    logic [31:0] mem_dat_w;
    logic [3:0]  mem_sel;
    logic [31:0] mem_dat_r;
    logic        mem_ack;
    int          check_errors;
    int          tests_done;

    // Memory model state
    logic [31:0] mem_words [logic [29:0]];
    integer      seed;
    logic        mem_busy;
    int          mem_wait;

    // Stimulus table
    string       t_name  [NUM_TESTS];
    logic        t_we    [NUM_TESTS];
    logic [31:0] t_adr   [NUM_TESTS];
    logic [31:0] t_dat   [NUM_TESTS];
    logic [3:0]  t_sel   [NUM_TESTS];
    int          t_reads [NUM_TESTS];

    cache_top #(
        .NUM_BANKS (NUM_BANKS),
        .LINES     (LINES)
    ) i_cache_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_dat_w (cpu_dat_w),
        .cpu_sel   (cpu_sel),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_sel   (mem_sel),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    cache_checker #(
        .NUM_BANKS (NUM_BANKS),
        .LINES     (LINES)
    ) i_cache_checker (
        .clock       (clock),
        .rst_n       (rst_n),
        .cpu_cyc     (cpu_cyc),
        .cpu_stb     (cpu_stb),
        .cpu_we      (cpu_we),
        .cpu_adr     (cpu_adr),
        .cpu_dat_w   (cpu_dat_w),
        .cpu_sel     (cpu_sel),
        .cpu_dat_r   (cpu_dat_r),
        .cpu_ack     (cpu_ack),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_dat_w   (mem_dat_w),
        .mem_sel     (mem_sel),
        .mem_ack     (mem_ack),
        .error_count (check_errors),
        .tests_done  (tests_done)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////
    // Memory model
    ////////////////////

    function automatic logic [31:0] read_word(input logic [29:0] waddr);
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return {2'b00, waddr} ^ 32'h5a5a0000;
    endfunction

    // Ack after 0 to 3 wait cycles, then one idle cycle
    always @(posedge clock) begin
        logic [31:0] word;
        if (!rst_n || mem_ack) begin
            mem_ack  <= 1'b0;
            mem_busy = 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $unsigned($random(seed)) % 4;
            end
            if (mem_wait == 0) begin
                word = read_word(mem_adr[31:2]);
                mem_ack   <= 1'b1;
                mem_dat_r <= word;
                if (mem_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_sel[b]) begin
                            word[8*b +: 8] = mem_dat_w[8*b +: 8];
                        end
                    end
                    mem_words[mem_adr[31:2]] = word;
                end
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    ////////////////////
    // Test table
    ////////////////////

    task automatic put_entry(input int i, input string name, input logic we,
                             input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input int reads);
        t_name[i]  = name;
        t_we[i]    = we;
        t_adr[i]   = adr;
        t_dat[i]   = dat;
        t_sel[i]   = sel;
        t_reads[i] = reads;
    endtask

    task automatic load_table();
        put_entry(0,  "cold_read",        1'b0, 32'h0000_1040, 32'h0,         4'hf, NUM_BANKS);
        put_entry(1,  "same_line_read",   1'b0, 32'h0000_104c, 32'h0,         4'hf, 0);
        put_entry(2,  "write_hit",        1'b1, 32'h0000_1044, 32'hdead_beef, 4'h5, 0);
        put_entry(3,  "read_merged",      1'b0, 32'h0000_1044, 32'h0,         4'hf, 0);
        put_entry(4,  "write_miss",       1'b1, 32'h0000_2080, 32'h1234_5678, 4'hc, 0);
        put_entry(5,  "read_after_wmiss", 1'b0, 32'h0000_2080, 32'h0,         4'hf, NUM_BANKS);
        put_entry(6,  "evict_read",       1'b0, 32'h0000_3040, 32'h0,         4'hf, NUM_BANKS);
        put_entry(7,  "reread_evicted",   1'b0, 32'h0000_1044, 32'h0,         4'hf, NUM_BANKS);
        put_entry(8,  "write_full_word",  1'b1, 32'h0000_1048, 32'ha5a5_0f0f, 4'hf, 0);
        put_entry(9,  "read_full_word",   1'b0, 32'h0000_1048, 32'h0,         4'hf, 0);
        put_entry(10, "top_index_read",   1'b0, 32'h0000_fff0, 32'h0,         4'hf, NUM_BANKS);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int cycles;
        bit timed_out;
        timed_out = 1'b0;
        seed      = 32'h6ee2;
        rst_n     = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        cpu_sel   = '0;
        mem_dat_r = '0;
        mem_ack   = 1'b0;
        mem_busy  = 1'b0;
        mem_wait  = 0;
        load_table();
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        // Quiet stretch before the first request
        repeat (5) @(posedge clock);
        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            @(negedge clock);
            i_cache_checker.start_test(t_name[i], t_reads[i]);
            @(posedge clock);
            cpu_cyc   <= 1'b1;
            cpu_stb   <= 1'b1;
            cpu_we    <= t_we[i];
            cpu_adr   <= t_adr[i];
            cpu_dat_w <= t_dat[i];
            cpu_sel   <= t_sel[i];
            cycles = 0;
            @(negedge clock);
            while (!cpu_ack && cycles < ACK_LIMIT) begin
                @(negedge clock);
                cycles++;
            end
            if (!cpu_ack) begin
                $display("Timeout: no cpu_ack within %0d cycles in %s", ACK_LIMIT, t_name[i]);
                timed_out = 1'b1;
            end
            @(posedge clock);
            cpu_cyc <= 1'b0;
            cpu_stb <= 1'b0;
            cpu_we  <= 1'b0;
        end
        repeat (3) @(negedge clock);
        i_cache_checker.print_summary();
        if (!timed_out && check_errors == 0 && tests_done == NUM_TESTS) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/cache_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_bank #(
    parameter  int LINES = 16,
    localparam int IDX_W = $clog2(LINES)
) (
    input  wire                              clock,
    input  wire                              en,
    input  wire                              we,
    input  wire  [cache_pkg::SEL_W-1:0]      wmask,
    input  wire  [IDX_W-1:0]                 idx,
    input  wire  [cache_pkg::DATA_W-1:0]     wdata,
    output logic [cache_pkg::DATA_W-1:0]     rdata
);

    // One word of every line
    logic [cache_pkg::DATA_W-1:0] mem [LINES];

    ////////////////////
    // Single port access
    ////////////////////

    always_ff @(posedge clock) begin
        if (en) begin
            if (we) begin
                // Only the selected byte lanes change
                for (int b = 0; b < cache_pkg::SEL_W; b++) begin
                    if (wmask[b]) begin
                        mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl #(
    parameter  int NUM_BANKS = 4,
    parameter  int LINES     = 16,
    localparam int OFF_W     = $clog2(NUM_BANKS),
    localparam int IDX_W     = $clog2(LINES)
) (
    input  wire                              clock,
    input  wire                              rst_n,

    // Processor side, Wishbone slave
    input  wire                              cpu_cyc,
    input  wire                              cpu_stb,
    input  wire                              cpu_we,
    input  wire  [cache_pkg::ADDR_W-1:0]     cpu_adr,
    input  wire  [cache_pkg::DATA_W-1:0]     cpu_dat_w,
    input  wire  [cache_pkg::SEL_W-1:0]      cpu_sel,
    output logic                             cpu_ack,

    // Memory side, Wishbone master
    output logic                             mem_cyc,
    output logic                             mem_stb,
    output logic                             mem_we,
    output logic [cache_pkg::ADDR_W-1:0]     mem_adr,
    output logic [cache_pkg::DATA_W-1:0]     mem_dat_w,
    output logic [cache_pkg::SEL_W-1:0]      mem_sel,
    input  wire  [cache_pkg::DATA_W-1:0]     mem_dat_r,
    input  wire                              mem_ack,

    // Bank feed
    output logic [IDX_W-1:0]                 bank_idx,
    output logic [NUM_BANKS-1:0]             bank_en,
    output logic                             bank_we,
    output logic [cache_pkg::SEL_W-1:0]      bank_wmask,
    output logic [cache_pkg::DATA_W-1:0]     bank_wdata,

    // Line select control
    output logic [OFF_W-1:0]                 word_off,
    output logic                             capture,
    output logic                             fill_capture
);

    localparam int BYTE_W = $clog2(cache_pkg::SEL_W);
    localparam int TAG_W  = cache_pkg::ADDR_W - BYTE_W - OFF_W - IDX_W;

    cache_pkg::cache_state_e state_q;
    cache_pkg::cache_state_e state_d;

    logic [TAG_W-1:0]  tag_q [LINES];
    logic [LINES-1:0]  valid_q;
    logic [OFF_W-1:0]  fill_cnt_q;
    logic              wr_hit_q;

    logic              req;
    logic [TAG_W-1:0]  req_tag;
    logic [IDX_W-1:0]  req_idx;
    logic              hit;
    logic              fill_ack;
    logic              fill_last;
    logic              wr_ack;

    ////////////////////
    // Address split
    ////////////////////

    assign req      = cpu_cyc & cpu_stb;
    assign req_tag  = cpu_adr[cache_pkg::ADDR_W-1 -: TAG_W];
    assign req_idx  = cpu_adr[BYTE_W+OFF_W +: IDX_W];
    assign word_off = cpu_adr[BYTE_W +: OFF_W];

    // Hit test against the stored tag
    assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign fill_ack  = (state_q == cache_pkg::st_refill_wait) && mem_ack;
    assign fill_last = (fill_cnt_q == OFF_W'(NUM_BANKS - 1));
    assign wr_ack    = (state_q == cache_pkg::st_write_thru) && mem_ack;

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::st_idle: begin
                if (req) begin
                    state_d = cache_pkg::st_lookup;
                end
            end
            cache_pkg::st_lookup: begin
                if (cpu_we) begin
                    state_d = cache_pkg::st_write_thru;
                end else if (hit) begin
                    state_d = cache_pkg::st_respond;
                end else begin
                    state_d = cache_pkg::st_refill_req;
                end
            end
            // Bus idle for one cycle between single reads
            cache_pkg::st_refill_req: begin
                state_d = cache_pkg::st_refill_wait;
            end
            cache_pkg::st_refill_wait: begin
                if (mem_ack) begin
                    state_d = fill_last ? cache_pkg::st_respond : cache_pkg::st_refill_req;
                end
            end
            cache_pkg::st_write_thru: begin
                if (mem_ack) begin
                    state_d = cache_pkg::st_respond;
                end
            end
            default: begin
                state_d = cache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= cache_pkg::st_idle;
            valid_q    <= '0;
            fill_cnt_q <= '0;
            wr_hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_pkg::st_lookup) begin
                wr_hit_q   <= hit;
                fill_cnt_q <= '0;
                // Line is about to be overwritten by the refill
                if (!cpu_we && !hit) begin
                    valid_q[req_idx] <= 1'b0;
                end
            end
            if (fill_ack) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
                if (fill_last) begin
                    valid_q[req_idx] <= 1'b1;
                end
            end
        end
    end

    // Tag written with the last refill word
    always_ff @(posedge clock) begin
        if (fill_ack && fill_last) begin
            tag_q[req_idx] <= req_tag;
        end
    end

    ////////////////////
    // Wishbone outputs
    ////////////////////

    assign cpu_ack = (state_q == cache_pkg::st_respond);

    assign mem_cyc   = (state_q == cache_pkg::st_refill_wait) ||
                       (state_q == cache_pkg::st_write_thru);
    assign mem_stb   = mem_cyc;
    assign mem_we    = (state_q == cache_pkg::st_write_thru);
    assign mem_dat_w = cpu_dat_w;
    assign mem_sel   = mem_we ? cpu_sel : '1;

    // Writes go to the word itself, refill walks the line
    assign mem_adr = mem_we ? {cpu_adr[cache_pkg::ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}}
                            : {req_tag, req_idx, fill_cnt_q, {BYTE_W{1'b0}}};

    ////////////////////
    // Bank feed
    ////////////////////

    always_comb begin
        bank_idx   = req_idx;
        bank_en    = '0;
        bank_we    = 1'b0;
        bank_wmask = cpu_sel;
        bank_wdata = cpu_dat_w;
        // Read all lanes so the lookup cycle sees the line
        if (state_q == cache_pkg::st_idle && req && !cpu_we) begin
            bank_en = '1;
        end
        if (fill_ack) begin
            bank_en    = NUM_BANKS'(1) << fill_cnt_q;
            bank_we    = 1'b1;
            bank_wmask = '1;
            bank_wdata = mem_dat_r;
        end
        if (wr_ack && wr_hit_q) begin
            bank_en = NUM_BANKS'(1) << word_off;
            bank_we = 1'b1;
        end
    end

    assign capture      = (state_q == cache_pkg::st_lookup) && !cpu_we && hit;
    assign fill_capture = fill_ack && (fill_cnt_q == word_off);

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Processor and memory words are the same size
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;
    localparam int ADDR_W = 32;

    ////////////////////
    // Controller FSM
    ////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill_req,
        st_refill_wait,
        st_write_thru,
        st_respond
    } cache_state_e;

endpackage

`default_nettype wire

// ==== logic/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top #(
    parameter int NUM_BANKS = 4,
    parameter int LINES     = 16
) (
    input  wire                              clock,
    input  wire                              rst_n,

    // Processor port
    input  wire                              cpu_cyc,
    input  wire                              cpu_stb,
    input  wire                              cpu_we,
    input  wire  [cache_pkg::ADDR_W-1:0]     cpu_adr,
    input  wire  [cache_pkg::DATA_W-1:0]     cpu_dat_w,
    input  wire  [cache_pkg::SEL_W-1:0]      cpu_sel,
    output logic [cache_pkg::DATA_W-1:0]     cpu_dat_r,
    output logic                             cpu_ack,

    // Memory port
    output logic                             mem_cyc,
    output logic                             mem_stb,
    output logic                             mem_we,
    output logic [cache_pkg::ADDR_W-1:0]     mem_adr,
    output logic [cache_pkg::DATA_W-1:0]     mem_dat_w,
    output logic [cache_pkg::SEL_W-1:0]      mem_sel,
    input  wire  [cache_pkg::DATA_W-1:0]     mem_dat_r,
    input  wire                              mem_ack
);

    localparam int OFF_W = $clog2(NUM_BANKS);
    localparam int IDX_W = $clog2(LINES);

    logic [IDX_W-1:0]                         bank_idx;
    logic [NUM_BANKS-1:0]                     bank_en;
    logic                                     bank_we;
    logic [cache_pkg::SEL_W-1:0]              bank_wmask;
    logic [cache_pkg::DATA_W-1:0]             bank_wdata;
    logic [NUM_BANKS*cache_pkg::DATA_W-1:0]   bank_rdata;
    logic [OFF_W-1:0]                         word_off;
    logic                                     capture;
    logic                                     fill_capture;

    ////////////////////
    // Controller
    ////////////////////

    cache_ctrl #(
        .NUM_BANKS (NUM_BANKS),
        .LINES     (LINES)
    ) i_cache_ctrl (
        .clock        (clock),
        .rst_n        (rst_n),
        .cpu_cyc      (cpu_cyc),
        .cpu_stb      (cpu_stb),
        .cpu_we       (cpu_we),
        .cpu_adr      (cpu_adr),
        .cpu_dat_w    (cpu_dat_w),
        .cpu_sel      (cpu_sel),
        .cpu_ack      (cpu_ack),
        .mem_cyc      (mem_cyc),
        .mem_stb      (mem_stb),
        .mem_we       (mem_we),
        .mem_adr      (mem_adr),
        .mem_dat_w    (mem_dat_w),
        .mem_sel      (mem_sel),
        .mem_dat_r    (mem_dat_r),
        .mem_ack      (mem_ack),
        .bank_idx     (bank_idx),
        .bank_en      (bank_en),
        .bank_we      (bank_we),
        .bank_wmask   (bank_wmask),
        .bank_wdata   (bank_wdata),
        .word_off     (word_off),
        .capture      (capture),
        .fill_capture (fill_capture)
    );

    ////////////////////
    // Word lanes
    ////////////////////

    // Bank k holds word k of every line
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        cache_bank #(
            .LINES (LINES)
        ) i_cache_bank (
            .clock (clock),
            .en    (bank_en[b]),
            .we    (bank_we),
            .wmask (bank_wmask),
            .idx   (bank_idx),
            .wdata (bank_wdata),
            .rdata (bank_rdata[b*cache_pkg::DATA_W +: cache_pkg::DATA_W])
        );
    end

    ////////////////////
    // Read data
    ////////////////////

    line_select #(
        .NUM_BANKS (NUM_BANKS)
    ) i_line_select (
        .clock        (clock),
        .rst_n        (rst_n),
        .bank_rdata   (bank_rdata),
        .word_off     (word_off),
        .capture      (capture),
        .fill_capture (fill_capture),
        .mem_dat_r    (mem_dat_r),
        .cpu_dat_r    (cpu_dat_r)
    );

endmodule

`default_nettype wire

// ==== logic/line_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_select #(
    parameter  int NUM_BANKS = 4,
    localparam int OFF_W     = $clog2(NUM_BANKS)
) (
    input  wire                                        clock,
    input  wire                                        rst_n,
    input  wire  [NUM_BANKS*cache_pkg::DATA_W-1:0]     bank_rdata,
    input  wire  [OFF_W-1:0]                           word_off,
    input  wire                                        capture,
    input  wire                                        fill_capture,
    input  wire  [cache_pkg::DATA_W-1:0]               mem_dat_r,
    output logic [cache_pkg::DATA_W-1:0]               cpu_dat_r
);

    logic [cache_pkg::DATA_W-1:0] sel_word;

    ////////////////////
    // Lane mux
    ////////////////////

    always_comb begin
        sel_word = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (word_off == OFF_W'(b)) begin
                sel_word = bank_rdata[b*cache_pkg::DATA_W +: cache_pkg::DATA_W];
            end
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    // A refill hands over the memory word directly, no bank read-back
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cpu_dat_r <= '0;
        end else if (fill_capture) begin
            cpu_dat_r <= mem_dat_r;
        end else if (capture) begin
            cpu_dat_r <= sel_word;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/cache_pkg.sv
logic/cache_bank.sv
logic/line_select.sv
logic/cache_ctrl.sv
logic/cache_top.sv
bench/cache_checker.sv
bench/tb_cache.sv
